/* compile.f */
hdl/terminal_pkg.sv
hdl/cursor_tracker.sv
hdl/screen_origin.sv
hdl/cell_writer.sv
hdl/stream_decoder.sv
hdl/terminal_stream.sv
tb/terminal_checker.sv
tb/terminal_stream_tb.sv

/* tb/terminal_stream_tb.sv */
`default_nettype none

module terminal_stream_tb;
	import terminal_pkg::*;

	localparam int COLUMNS = 8;
	localparam int ROWS = 4;
	localparam int MAX_TESTS = 64;

	logic clk;
	logic reset;
	logic byte_valid;
	char_t byte_in;
	logic ready;
	logic wr_request;
	cell_addr_t wr_address;
	cell_t wr_data;
	logic wr_done;
	cell_addr_t first_row;
	logic [127:0] test_name;

	// Stimulus table
	logic [127:0] name_table[MAX_TESTS];
	char_t byte_table[MAX_TESTS];
	int table_len = 0;
	int seed = 32'hd486_cb22;

	terminal_stream #(
		.COLUMNS(COLUMNS),
		.ROWS(ROWS)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.byte_valid(byte_valid),
		.byte_in(byte_in),
		.ready(ready),
		.wr_request(wr_request),
		.wr_address(wr_address),
		.wr_data(wr_data),
		.wr_done(wr_done),
		.first_row(first_row)
	);

	terminal_checker #(
		.COLUMNS(COLUMNS),
		.ROWS(ROWS)
	) scoreboard_i (
		.clk(clk),
		.reset(reset),
		.byte_valid(byte_valid),
		.byte_in(byte_in),
		.ready(ready),
		.wr_request(wr_request),
		.wr_address(wr_address),
		.wr_data(wr_data),
		.wr_done(wr_done),
		.first_row(first_row),
		.test_name(test_name)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================================================
	// Table contents
	// ========================================================================
	task automatic add_byte(input logic [127:0] name, input char_t code);
		name_table[table_len] = name;
		byte_table[table_len] = code;
		table_len++;
	endtask

	task automatic add_text(input logic [127:0] name, input string text);
		for (int i = 0; i < text.len(); i++)
			add_byte(name, char_t'(text[i]));
	endtask

	task automatic build_table();
		add_text("wrap", "ABCDEFGHI");
		add_byte("color_fg", 8'h02);
		add_byte("color_fg", 8'h04);
		add_text("color_fg", "J");
		add_byte("color_bg", 8'h02);
		add_byte("color_bg", 8'h13);
		add_text("color_bg", "K");
		add_byte("return", 8'h0d);
		add_text("return", "L");
		add_byte("line_feed", 8'h0a);
		add_text("line_feed", "M");
		add_byte("ignored", 8'h05);
		add_byte("ignored", 8'h1f);
		add_text("ignored", "n");
		// Second LF scrolls from the bottom row
		add_byte("lf_scroll", 8'h0a);
		add_byte("lf_scroll", 8'h0a);
		add_text("lf_scroll", "N");
		add_byte("wrap_scroll", 8'h0d);
		add_text("wrap_scroll", "01234567P");
		// first_row goes 2, 3 then back to 0
		add_byte("scroll_modulo", 8'h0a);
		add_byte("scroll_modulo", 8'h0a);
		add_text("scroll_modulo", "Q");
		// One more scroll leaves first_row at 1 before the clear
		add_byte("clear", 8'h0a);
		add_byte("clear", 8'h02);
		add_byte("clear", 8'h15);
		add_byte("clear", 8'h01);
		add_text("clear", "Z");
		add_byte("high_byte", 8'ha5);
	endtask

	// Waits for ready, then holds the byte for the accepting edge
	task automatic send_byte(input char_t code);
		while (!ready) begin
			@(posedge clk);
			#1;
		end
		byte_in = code;
		byte_valid = 1'b1;
		@(posedge clk);
		#1;
		byte_valid = 1'b0;
	endtask

	// Memory answers each request after 1 to 3 cycles
	initial begin
		int delay;
		wr_done = 1'b0;
		forever begin
			@(posedge clk);
			if (wr_request) begin
				delay = 1 + ({$random(seed)} % 3);
				repeat (delay - 1) @(posedge clk);
				#1;
				wr_done = 1'b1;
				@(posedge clk);
				#1;
				wr_done = 1'b0;
			end
		end
	end

	initial begin
		wait (table_len > 0);
		#(table_len * (ROWS * COLUMNS + 4) * 40);
		$display("Timeout: the DUT stopped making progress before the table was done");
		scoreboard_i.finish_checks();
		$display("Verification failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		byte_valid = 1'b0;
		byte_in = 8'h00;
		test_name = "power_up";
		build_table();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < table_len; i++) begin
			test_name = name_table[i];
			send_byte(byte_table[i]);
		end
		while (!ready) begin
			@(posedge clk);
			#1;
		end
		repeat (4) @(posedge clk);
		scoreboard_i.finish_checks();
		if (scoreboard_i.error_total() == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/terminal_checker.sv */
`default_nettype none

module terminal_checker #(
	parameter int COLUMNS = 16,
	parameter int ROWS = 4
) (
	input logic clk,
	input logic reset,
	input logic byte_valid,
	input terminal_pkg::char_t byte_in,
	input logic ready,
	input logic wr_request,
	input terminal_pkg::cell_addr_t wr_address,
	input terminal_pkg::cell_t wr_data,
	input logic wr_done,
	input terminal_pkg::cell_addr_t first_row,
	input logic [127:0] test_name
);
	import terminal_pkg::*;

	cell_addr_t exp_address[$];
	cell_t exp_data[$];
	logic [127:0] exp_name[$];

	// Screen model
	int cur_col;
	int cur_row;
	int top_row;
	color_t fg;
	color_t bg;
	logic color_next;
	logic power_up_due;
	logic outstanding;

	int value_errors = 0;
	int extra_errors = 0;
	int missing_errors = 0;
	int other_errors = 0;

	// ========================================================================
	// Prediction
	// ========================================================================
	task automatic expect_run(input int address, input int count, input char_t code,
			input logic [127:0] name);
		for (int i = 0; i < count; i++) begin
			exp_address.push_back(cell_addr_t'(address + i));
			exp_data.push_back({code, fg, bg, 16'h0000});
			exp_name.push_back(name);
		end
	endtask

	task automatic move_down(input logic [127:0] name);
		if (cur_row == ROWS - 1) begin
			// Old top row is blanked and becomes the bottom
			expect_run(top_row * COLUMNS, COLUMNS, 8'h20, name);
			top_row = (top_row + 1) % ROWS;
		end else begin
			cur_row++;
		end
	endtask

	task automatic apply_byte(input char_t code, input logic [127:0] name);
		if (color_next) begin
			if (code[4])
				bg = code[3:0];
			else
				fg = code[3:0];
			color_next = 1'b0;
		end else if (code == 8'h01) begin
			expect_run(0, ROWS * COLUMNS, 8'h20, name);
			top_row = 0;
			cur_col = 0;
			cur_row = 0;
		end else if (code >= 8'h20) begin
			expect_run(((cur_row + top_row) % ROWS) * COLUMNS + cur_col, 1, code, name);
			cur_col++;
			if (cur_col == COLUMNS) begin
				cur_col = 0;
				move_down(name);
			end
		end else if (code == 8'h02) begin
			color_next = 1'b1;
		end else if (code == 8'h0a) begin
			move_down(name);
		end else if (code == 8'h0d) begin
			cur_col = 0;
		end
	endtask

	// ========================================================================
	// Comparison
	// ========================================================================
	task automatic check_write();
		cell_addr_t address;
		cell_t data;
		logic [127:0] name;
		if (exp_address.size() == 0) begin
			extra_errors++;
			$display("Write to address %h with data %h arrived while no write was expected",
				wr_address, wr_data);
		end else begin
			address = exp_address.pop_front();
			data = exp_data.pop_front();
			name = exp_name.pop_front();
			if (wr_address !== address || wr_data !== data) begin
				value_errors++;
				$display("Error %0s: expected write %h <= %h, actual write %h <= %h",
					name, address, data, wr_address, wr_data);
			end
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			exp_address.delete();
			exp_data.delete();
			exp_name.delete();
			cur_col = 0;
			cur_row = 0;
			top_row = 0;
			fg = 4'd7;
			bg = 4'd0;
			color_next = 1'b0;
			power_up_due = 1'b1;
			outstanding = 1'b0;
		end else begin
			if (power_up_due) begin
				expect_run(0, ROWS * COLUMNS, 8'h20, "power_up");
				power_up_due = 1'b0;
			end
			if (wr_done)
				outstanding = 1'b0;
			if (wr_request) begin
				if (outstanding) begin
					other_errors++;
					$display("Write request issued while the previous write was outstanding");
				end
				outstanding = 1'b1;
				check_write();
			end
			if (byte_valid && ready) begin
				if (exp_address.size() != 0) begin
					other_errors++;
					$display("Byte accepted while %0d expected writes were still pending",
						exp_address.size());
				end
				if (first_row !== cell_addr_t'(top_row)) begin
					value_errors++;
					$display("Error %0s: first_row expected %0d, actual %0d",
						test_name, top_row, first_row);
				end
				apply_byte(byte_in, test_name);
			end
		end
	end

	task automatic finish_checks();
		if (exp_address.size() != 0) begin
			missing_errors += exp_address.size();
			$display("%0d expected writes never arrived, the first from test %0s",
				exp_address.size(), exp_name[0]);
		end
		if (first_row !== cell_addr_t'(top_row)) begin
			value_errors++;
			$display("Error end_of_run: first_row expected %0d, actual %0d", top_row, first_row);
		end
		$display("Errors: %0d wrong values, %0d unexpected writes, %0d missing writes, %0d other",
			value_errors, extra_errors, missing_errors, other_errors);
	endtask

	function automatic int error_total();
		return value_errors + extra_errors + missing_errors + other_errors;
	endfunction

endmodule

`default_nettype wire

/* hdl/terminal_stream.sv */
`default_nettype none

module terminal_stream #(
	parameter int COLUMNS = 16,
	parameter int ROWS = 4
) (
	input logic clk,
	input logic reset,
	input logic byte_valid,
	input terminal_pkg::char_t byte_in,
	output logic ready,
	output logic wr_request,
	output terminal_pkg::cell_addr_t wr_address,
	output terminal_pkg::cell_t wr_data,
	input logic wr_done,
	output terminal_pkg::cell_addr_t first_row
);
	import terminal_pkg::*;

	cursor_cmd_t cmd;
	cell_addr_t cur_x;
	cell_addr_t cur_y;
	cell_addr_t cell_address;
	cell_addr_t blank_address;
	cell_addr_t start_address;
	cell_addr_t word_count;
	cell_t cell_value;
	logic scroll;
	logic home;
	logic start;
	logic finished;

	stream_decoder #(
		.COLUMNS(COLUMNS),
		.ROWS(ROWS)
	) decoder_i (
		.clk(clk),
		.reset(reset),
		.byte_valid(byte_valid),
		.byte_in(byte_in),
		.ready(ready),
		.cmd(cmd),
		.scroll(scroll),
		.home(home),
		.cell_address(cell_address),
		.blank_address(blank_address),
		.start(start),
		.start_address(start_address),
		.word_count(word_count),
		.cell_value(cell_value),
		.finished(finished)
	);

	cursor_tracker #(
		.COLUMNS(COLUMNS),
		.ROWS(ROWS)
	) cursor_i (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.cur_x(cur_x),
		.cur_y(cur_y),
		.scroll(scroll)
	);

	screen_origin #(
		.COLUMNS(COLUMNS),
		.ROWS(ROWS)
	) origin_i (
		.clk(clk),
		.reset(reset),
		.scroll(scroll),
		.home(home),
		.cur_x(cur_x),
		.cur_y(cur_y),
		.cell_address(cell_address),
		.blank_address(blank_address),
		.first_row(first_row)
	);

	cell_writer writer_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.start_address(start_address),
		.word_count(word_count),
		.cell_value(cell_value),
		.wr_done(wr_done),
		.wr_request(wr_request),
		.wr_address(wr_address),
		.wr_data(wr_data),
		.finished(finished)
	);

endmodule

`default_nettype wire

/* hdl/stream_decoder.sv */
`default_nettype none

module stream_decoder #(
	parameter int COLUMNS = 16,
	parameter int ROWS = 4
) (
	input logic clk,
	input logic reset,
	input logic byte_valid,
	input terminal_pkg::char_t byte_in,
	output logic ready,
	output terminal_pkg::cursor_cmd_t cmd,
	input logic scroll,
	output logic home,
	input terminal_pkg::cell_addr_t cell_address,
	input terminal_pkg::cell_addr_t blank_address,
	output logic start,
	output terminal_pkg::cell_addr_t start_address,
	output terminal_pkg::cell_addr_t word_count,
	output terminal_pkg::cell_t cell_value,
	input logic finished
);
	import terminal_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		COLOR_ARG,
		WRITE,
		ADVANCE,
		SCROLL_CHECK,
		BLANK
	} decoder_state_t;

	decoder_state_t state;
	color_t fg;
	color_t bg;
	logic clearing;
	logic blank_busy;
	logic take;

	assign take = byte_valid && ready;

	// ========================================================================
	// Byte handling and sequencing
	// ========================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			ready <= 1'b0;
			cmd <= CMD_NONE;
			home <= 1'b0;
			start <= 1'b0;
			fg <= DEFAULT_FG;
			bg <= DEFAULT_BG;
			// Power-up clear runs first
			clearing <= 1'b1;
			blank_busy <= 1'b0;
		end else begin
			cmd <= CMD_NONE;
			home <= 1'b0;
			start <= 1'b0;
			case (state)
				IDLE: begin
					if (clearing || (take && byte_in == CODE_CLEAR)) begin
						clearing <= 1'b1;
						home <= 1'b1;
						cmd <= CMD_HOME;
						ready <= 1'b0;
						state <= ADVANCE;
					end else if (take && byte_in >= CODE_FIRST_PRINTABLE) begin
						start <= 1'b1;
						start_address <= cell_address;
						word_count <= cell_addr_t'(1);
						cell_value <= make_cell(byte_in, fg, bg);
						ready <= 1'b0;
						state <= WRITE;
					end else if (take) begin
						case (byte_in)
							CODE_COLOR: state <= COLOR_ARG;
							CODE_LF: begin
								cmd <= CMD_LINE_FEED;
								ready <= 1'b0;
								state <= ADVANCE;
							end
							CODE_CR: begin
								cmd <= CMD_RETURN;
								ready <= 1'b0;
								state <= ADVANCE;
							end
							default: begin
							end
						endcase
					end
				end
				COLOR_ARG: begin
					if (take) begin
						if (byte_in[4])
							bg <= byte_in[3:0];
						else
							fg <= byte_in[3:0];
						state <= IDLE;
					end
				end
				WRITE: begin
					if (finished) begin
						cmd <= CMD_NEXT_CHAR;
						state <= ADVANCE;
					end
				end
				// Command on the wire this cycle
				ADVANCE: state <= SCROLL_CHECK;
				SCROLL_CHECK: begin
					if (clearing) begin
						word_count <= cell_addr_t'(ROWS * COLUMNS);
						state <= BLANK;
					end else if (scroll) begin
						word_count <= cell_addr_t'(COLUMNS);
						state <= BLANK;
					end else begin
						ready <= 1'b1;
						state <= IDLE;
					end
				end
				BLANK: begin
					// blank_address is settled by now
					if (!blank_busy) begin
						start <= 1'b1;
						start_address <= blank_address;
						cell_value <= make_cell(SPACE, fg, bg);
						blank_busy <= 1'b1;
					end else if (finished) begin
						blank_busy <= 1'b0;
						clearing <= 1'b0;
						ready <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/cell_writer.sv */
`default_nettype none

module cell_writer (
	input logic clk,
	input logic reset,
	input logic start,
	input terminal_pkg::cell_addr_t start_address,
	input terminal_pkg::cell_addr_t word_count,
	input terminal_pkg::cell_t cell_value,
	input logic wr_done,
	output logic wr_request,
	output terminal_pkg::cell_addr_t wr_address,
	output terminal_pkg::cell_t wr_data,
	output logic finished
);
	import terminal_pkg::*;

	typedef enum logic {
		IDLE,
		WAIT_DONE
	} writer_state_t;

	writer_state_t state;
	cell_addr_t remaining;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			wr_request <= 1'b0;
			finished <= 1'b0;
		end else begin
			wr_request <= 1'b0;
			finished <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						wr_request <= 1'b1;
						state <= WAIT_DONE;
					end
				end
				WAIT_DONE: begin
					if (wr_done) begin
						if (remaining == cell_addr_t'(1)) begin
							finished <= 1'b1;
							state <= IDLE;
						end else begin
							wr_request <= 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Address, data and count of the run in progress
	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			wr_address <= start_address;
			wr_data <= cell_value;
			remaining <= word_count;
		end else if (state == WAIT_DONE && wr_done) begin
			wr_address <= wr_address + 1'b1;
			remaining <= remaining - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/screen_origin.sv */
`default_nettype none

module screen_origin #(
	parameter int COLUMNS = 16,
	parameter int ROWS = 4
) (
	input logic clk,
	input logic reset,
	input logic scroll,
	input logic home,
	input terminal_pkg::cell_addr_t cur_x,
	input terminal_pkg::cell_addr_t cur_y,
	output terminal_pkg::cell_addr_t cell_address,
	output terminal_pkg::cell_addr_t blank_address,
	output terminal_pkg::cell_addr_t first_row
);
	import terminal_pkg::*;

	localparam cell_addr_t ROW_COUNT = cell_addr_t'(ROWS);
	localparam cell_addr_t COL_COUNT = cell_addr_t'(COLUMNS);

	cell_addr_t row_sum;
	cell_addr_t phys_row;

	// Logical row to physical row, modulo ROWS
	assign row_sum = cur_y + first_row;
	assign phys_row = (row_sum >= ROW_COUNT) ? row_sum - ROW_COUNT : row_sum;
	assign cell_address = cell_addr_t'(phys_row * COL_COUNT) + cur_x;

	always_ff @(posedge clk) begin
		if (reset)
			first_row <= '0;
		else if (home)
			first_row <= '0;
		else if (scroll)
			first_row <= (first_row == ROW_COUNT - 1'b1) ? '0 : first_row + 1'b1;
	end

	// Old top row becomes the new bottom row
	always_ff @(posedge clk) begin
		if (home)
			blank_address <= '0;
		else if (scroll)
			blank_address <= cell_addr_t'(first_row * COL_COUNT);
	end

endmodule

`default_nettype wire

/* hdl/cursor_tracker.sv */
`default_nettype none

module cursor_tracker #(
	parameter int COLUMNS = 16,
	parameter int ROWS = 4
) (
	input logic clk,
	input logic reset,
	input terminal_pkg::cursor_cmd_t cmd,
	output terminal_pkg::cell_addr_t cur_x,
	output terminal_pkg::cell_addr_t cur_y,
	output logic scroll
);
	import terminal_pkg::*;

	localparam cell_addr_t LAST_COL = cell_addr_t'(COLUMNS - 1);
	localparam cell_addr_t LAST_ROW = cell_addr_t'(ROWS - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			cur_x <= '0;
			cur_y <= '0;
			scroll <= 1'b0;
		end else begin
			scroll <= 1'b0;
			case (cmd)
				CMD_NEXT_CHAR: begin
					if (cur_x == LAST_COL) begin
						cur_x <= '0;
						// Wrap past the bottom row scrolls instead
						if (cur_y == LAST_ROW)
							scroll <= 1'b1;
						else
							cur_y <= cur_y + 1'b1;
					end else begin
						cur_x <= cur_x + 1'b1;
					end
				end
				CMD_LINE_FEED: begin
					if (cur_y == LAST_ROW)
						scroll <= 1'b1;
					else
						cur_y <= cur_y + 1'b1;
				end
				CMD_RETURN: begin
					cur_x <= '0;
				end
				CMD_HOME: begin
					cur_x <= '0;
					cur_y <= '0;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/terminal_pkg.sv */
`default_nettype none

package terminal_pkg;

	// ========================================================================
	// Widths with a meaning
	// ========================================================================
	typedef logic [7:0] char_t;
	typedef logic [3:0] color_t;
	typedef logic [31:0] cell_t;
	typedef logic [15:0] cell_addr_t;

	// Commands from the decoder to the cursor
	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_NEXT_CHAR,
		CMD_LINE_FEED,
		CMD_RETURN,
		CMD_HOME
	} cursor_cmd_t;

	// ========================================================================
	// Control codes
	// ========================================================================
	localparam char_t CODE_CLEAR = 8'h01;
	localparam char_t CODE_COLOR = 8'h02;
	localparam char_t CODE_LF = 8'h0a;
	localparam char_t CODE_CR = 8'h0d;
	localparam char_t CODE_FIRST_PRINTABLE = 8'h20;
	localparam char_t SPACE = 8'h20;

	// Colours after reset
	localparam color_t DEFAULT_FG = 4'd7;
	localparam color_t DEFAULT_BG = 4'd0;

	// Cell layout: char 31:24, fg 23:20, bg 19:16, rest zero
	function automatic cell_t make_cell(
		input char_t code,
		input color_t fg,
		input color_t bg
	);
		return {code, fg, bg, 16'h0000};
	endfunction

endpackage

`default_nettype wire
